//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_gate_array
RTL_TOP ?= gate_array
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
PASS_MSG ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- common/gate_array_pkg.sv
package gate_array_pkg;

	// ==========================================================
	// Bus decode
	// ==========================================================

	// Gate array answers on A15:A14 = 01
	localparam logic [1:0] GA_SEL_BITS = 2'b01;
	// ROM select latch, A13 low
	localparam int unsigned ROMSEL_ADDR_BIT = 13;
	// RAM bank register, A15 low
	localparam int unsigned BANK_SEL_BIT = 15;

	// Memory regions for ROM overlay, by A15:A14
	localparam logic [1:0] UROM_PAGE = 2'b11;
	localparam logic [1:0] LROM_PAGE = 2'b00;

	// Function field in D7:D6
	localparam logic [1:0] FN_PEN = 2'd0;
	localparam logic [1:0] FN_INK = 2'd1;
	localparam logic [1:0] FN_RMR = 2'd2;
	localparam logic [1:0] FN_MMR = 2'd3;

	// ==========================================================
	// Video
	// ==========================================================

	// Screen modes, code 3 falls back to 4 bpp
	localparam logic [1:0] MODE_4BPP = 2'd0;
	localparam logic [1:0] MODE_2BPP = 2'd1;
	localparam logic [1:0] MODE_1BPP = 2'd2;

	// Last palette slot holds the border ink
	localparam logic [4:0] BORDER_PEN = 5'd16;

	// Hardware colour number to 24-bit RGB
	localparam logic [23:0] HW_COLOUR_RGB [32] = '{
		24'h7f7f7f, 24'h7f7f7f, 24'h00ff7f, 24'hffff7f,
		24'h00007f, 24'hff007f, 24'h007f7f, 24'hff7f7f,
		24'hff007f, 24'hffff7f, 24'hffff00, 24'hffffff,
		24'hff0000, 24'hff00ff, 24'hff7f00, 24'hff7fff,
		24'h00007f, 24'h00ff7f, 24'h00ff00, 24'h00ffff,
		24'h000000, 24'h0000ff, 24'h007f00, 24'h007fff,
		24'h7f007f, 24'h7fff7f, 24'h7fff00, 24'h7fffff,
		24'h7f0000, 24'h7f00ff, 24'h7f7f00, 24'h7f7fff
	};

	// ==========================================================
	// Raster interrupt
	// ==========================================================

	localparam logic [5:0] HSYNC_PERIOD = 6'd52;
	localparam logic [1:0] VSYNC_DELAY = 2'd2;
	localparam logic [6:0] INT_HOLD_MAX = 7'd96;

	// Command byte, same function field in every view
	typedef union packed {
		struct packed {
			logic [1:0] fn;
			logic       rsvd;
			logic [4:0] val;
		} pen;
		struct packed {
			logic [1:0] fn;
			logic       rsvd;
			logic       int_clear;
			logic       urom_dis;
			logic       lrom_dis;
			logic [1:0] mode;
		} rmr;
		struct packed {
			logic [1:0] fn;
			logic [5:0] cfg;
		} mmr;
	} ga_cmd_u;

endpackage

//--- interrupt/raster_interrupt.sv
`timescale 1ns/1ps

module raster_interrupt (
	input  logic clk_i,
	input  logic nreset_i,
	input  logic hsync_i,
	input  logic vsync_i,
	input  logic nioreq_i,
	input  logic nm1_i,
	input  logic int_clear_i,
	output logic nint_o
);
	import gate_array_pkg::*;

	logic       hsync_q;
	logic       vsync_q;
	logic       ack_q;
	logic       ack;
	logic       hsync_fall;
	logic       vsync_rise;
	logic       ack_rise;
	// Line counter, 0 to 51
	logic [5:0] line_cnt;
	logic [5:0] line_next;
	logic       line_wrap;
	// Vsync re-alignment
	logic       vs_pending;
	logic [1:0] vs_falls;
	logic       realign;
	logic       raise;
	logic [6:0] hold_cnt;

	// ==========================================================
	// Edge detection
	// ==========================================================

	// Z80 interrupt acknowledge, IORQ with M1
	assign ack = !nioreq_i && !nm1_i;
	assign hsync_fall = hsync_q && !hsync_i;
	assign vsync_rise = vsync_i && !vsync_q;
	assign ack_rise = ack && !ack_q;

	// ==========================================================
	// Line count
	// ==========================================================

	assign line_wrap = hsync_fall && (line_cnt == HSYNC_PERIOD - 6'd1);
	// Second hsync fall after vsync
	assign realign = vs_pending && hsync_fall && (vs_falls == VSYNC_DELAY - 2'd1);

	// Acknowledge drops bit 5, pushing the next interrupt out
	always_comb
	begin
		if (line_wrap)
			line_next = '0;
		else if (hsync_fall)
			line_next = line_cnt + 6'd1;
		else
			line_next = line_cnt;
		if (ack_rise)
			line_next[5] = 1'b0;
	end

	// Bit 5 set means 32 lines or more since the last interrupt
	assign raise = !int_clear_i && (realign ? line_cnt[5] : line_wrap);

	always_ff @(posedge clk_i)
	begin
		if (!nreset_i)
		begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			ack_q <= 1'b0;
			line_cnt <= '0;
			vs_pending <= 1'b0;
			vs_falls <= '0;
		end
		else
		begin
			hsync_q <= hsync_i;
			vsync_q <= vsync_i;
			ack_q <= ack;
			if (int_clear_i || realign)
				line_cnt <= '0;
			else
				line_cnt <= line_next;
			// Restart the wait on every vsync rise
			if (vsync_rise)
			begin
				vs_pending <= 1'b1;
				vs_falls <= '0;
			end
			else if (realign)
				vs_pending <= 1'b0;
			else if (vs_pending && hsync_fall)
				vs_falls <= vs_falls + 2'd1;
		end
	end

	// ==========================================================
	// Interrupt hold
	// ==========================================================

	// Non-zero while INT is asserted, counts clocks low
	always_ff @(posedge clk_i)
	begin
		if (!nreset_i)
			hold_cnt <= '0;
		else if (int_clear_i)
			hold_cnt <= '0;
		else if (raise && (hold_cnt == '0))
			hold_cnt <= 7'd1;
		else if (ack_rise || (hold_cnt == INT_HOLD_MAX))
			hold_cnt <= '0;
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt + 7'd1;
	end

	assign nint_o = (hold_cnt == '0);

	// Interrupt never outlasts the hold window
	a_int_hold: assert property (@(posedge clk_i) disable iff (!nreset_i)
		(hold_cnt == INT_HOLD_MAX) |=> nint_o)
		else $error("raster_interrupt: nint_o low past %0d clocks", INT_HOLD_MAX);

endmodule

//--- project.f
+incdir+testbench
common/gate_array_pkg.sv
source/gate_array_regs.sv
video/pixel_decoder.sv
interrupt/raster_interrupt.sv
source/gate_array.sv
testbench/tb_gate_array.sv

//--- source/gate_array.sv
`timescale 1ns/1ps

module gate_array (
	input  logic        clk_i,
	input  logic        nreset_i,
	// Z80 bus
	input  logic [15:0] a_i,
	input  logic [7:0]  d_i,
	input  logic        nwr_i,
	input  logic        nrd_i,
	input  logic        nmreq_i,
	input  logic        nioreq_i,
	input  logic        nm1_i,
	output logic        nint_o,
	// Memory map
	output logic        nromen_o,
	output logic [5:0]  romsel_o,
	output logic [8:0]  ramsel_o,
	// Video from the CRT controller
	input  logic [7:0]  dv_i,
	input  logic [2:0]  video_pixel_i,
	input  logic        border_i,
	input  logic        vsync_i,
	input  logic        hsync_i,
	output logic [23:0] color_dat_o
);

	// Palette update path
	logic       ink_we;
	logic [4:0] ink_pen;
	logic [4:0] ink_val;
	logic [1:0] mode;
	// RMR interrupt reset
	logic       int_clear;

	// ==========================================================
	// Blocks
	// ==========================================================

	gate_array_regs u_regs (
		.clk_i       (clk_i),
		.nreset_i    (nreset_i),
		.a_i         (a_i),
		.d_i         (d_i),
		.nwr_i       (nwr_i),
		.nrd_i       (nrd_i),
		.nmreq_i     (nmreq_i),
		.nioreq_i    (nioreq_i),
		.ink_we_o    (ink_we),
		.ink_pen_o   (ink_pen),
		.ink_val_o   (ink_val),
		.mode_o      (mode),
		.int_clear_o (int_clear),
		.nromen_o    (nromen_o),
		.romsel_o    (romsel_o),
		.ramsel_o    (ramsel_o)
	);

	pixel_decoder u_pixel (
		.clk_i         (clk_i),
		.nreset_i      (nreset_i),
		.dv_i          (dv_i),
		.video_pixel_i (video_pixel_i),
		.border_i      (border_i),
		.mode_i        (mode),
		.ink_we_i      (ink_we),
		.ink_pen_i     (ink_pen),
		.ink_val_i     (ink_val),
		.color_dat_o   (color_dat_o)
	);

	raster_interrupt u_irq (
		.clk_i       (clk_i),
		.nreset_i    (nreset_i),
		.hsync_i     (hsync_i),
		.vsync_i     (vsync_i),
		.nioreq_i    (nioreq_i),
		.nm1_i       (nm1_i),
		.int_clear_i (int_clear),
		.nint_o      (nint_o)
	);

endmodule

//--- source/gate_array_regs.sv
`timescale 1ns/1ps

module gate_array_regs (
	input  logic        clk_i,
	input  logic        nreset_i,
	input  logic [15:0] a_i,
	input  logic [7:0]  d_i,
	input  logic        nwr_i,
	input  logic        nrd_i,
	input  logic        nmreq_i,
	input  logic        nioreq_i,
	output logic        ink_we_o,
	output logic [4:0]  ink_pen_o,
	output logic [4:0]  ink_val_o,
	output logic [1:0]  mode_o,
	output logic        int_clear_o,
	output logic        nromen_o,
	output logic [5:0]  romsel_o,
	output logic [8:0]  ramsel_o
);
	import gate_array_pkg::*;

	// ==========================================================
	// Bus decode
	// ==========================================================

	ga_cmd_u    cmd;
	logic       io_wr;
	logic       ga_wr;
	logic       ink_wr;
	logic       rmr_wr;
	logic       ink_wr_q;
	logic       rmr_wr_q;
	logic       mem_rd;
	// Register state
	logic [4:0] pen_q;
	logic [1:0] mode_q;
	logic       urom_dis_q;
	logic       lrom_dis_q;
	logic [8:0] ramsel_q;
	logic [5:0] romsel_q;

	assign cmd = d_i;

	// Z80 I/O write, held for several clocks
	assign io_wr = !nioreq_i && !nwr_i;
	assign ga_wr = io_wr && (a_i[15:14] == GA_SEL_BITS);
	assign ink_wr = ga_wr && (cmd.pen.fn == FN_INK);
	assign rmr_wr = ga_wr && (cmd.pen.fn == FN_RMR);
	assign mem_rd = !nmreq_i && !nrd_i;

	// Strobes only on the first cycle of a write
	assign ink_we_o = ink_wr && !ink_wr_q;
	assign int_clear_o = rmr_wr && !rmr_wr_q && cmd.rmr.int_clear;

	assign ink_pen_o = pen_q;
	assign ink_val_o = cmd.pen.val;
	assign mode_o = mode_q;
	assign romsel_o = romsel_q;
	assign ramsel_o = ramsel_q;

	// ROM overlays the top and bottom 16K on reads
	// Disable bits are active high
	assign nromen_o = !(mem_rd && (((a_i[15:14] == UROM_PAGE) && !urom_dis_q) ||
		((a_i[15:14] == LROM_PAGE) && !lrom_dis_q)));

	// ==========================================================
	// Registers
	// ==========================================================

	always_ff @(posedge clk_i)
	begin
		if (!nreset_i)
		begin
			ink_wr_q <= 1'b0;
			rmr_wr_q <= 1'b0;
			pen_q <= '0;
			mode_q <= '0;
			urom_dis_q <= 1'b0;
			lrom_dis_q <= 1'b0;
			ramsel_q <= '0;
			romsel_q <= '0;
		end
		else
		begin
			ink_wr_q <= ink_wr;
			rmr_wr_q <= rmr_wr;
			// Pen pointer
			if (ga_wr && (cmd.pen.fn == FN_PEN))
				pen_q <= cmd.pen.val;
			// Mode and ROM enables
			if (rmr_wr)
			begin
				mode_q <= cmd.rmr.mode;
				urom_dis_q <= cmd.rmr.urom_dis;
				lrom_dis_q <= cmd.rmr.lrom_dis;
			end
			// Bank config plus A10:A8 for the extended pages, kept in page layout
			if (io_wr && !a_i[BANK_SEL_BIT] && (cmd.mmr.fn == FN_MMR))
				ramsel_q <= {cmd.mmr.cfg[2], a_i[10:8], cmd.mmr.cfg[5:3], cmd.mmr.cfg[1:0]};
			// Upper ROM number
			if (io_wr && !a_i[ROMSEL_ADDR_BIT])
				romsel_q <= d_i[5:0];
		end
	end

	// Palette and interrupt strobes fire once per CPU write
	a_strobe_single: assert property (@(posedge clk_i) disable iff (!nreset_i)
		(ink_we_o || int_clear_o) |=> !(ink_we_o || int_clear_o))
		else $error("gate_array_regs: write strobe held for two cycles");

endmodule

//--- testbench/tb_model.svh
	// ==========================================================
	// Reference model state
	// ==========================================================

	// Register shadows
	logic [4:0]  m_pen;
	logic [1:0]  m_mode;
	logic        m_urom_dis;
	logic        m_lrom_dis;
	logic [5:0]  m_romsel;
	logic [8:0]  m_ramsel;
	logic [4:0]  m_ink [17];
	logic        m_ink_wr_prev;
	logic        m_rmr_wr_prev;
	// Colour expected after the next edge
	logic [23:0] m_color;
	// Raster interrupt
	logic        m_hs_prev;
	logic        m_vs_prev;
	logic        m_ack_prev;
	logic [5:0]  m_count;
	logic        m_vs_wait;
	logic [1:0]  m_vs_falls;
	logic        m_low;
	logic [6:0]  m_low_clks;

	// Bit n of a video byte
	function automatic logic shifted_bit(input logic [7:0] dv, input int n);
		logic [7:0] s;
		s = dv >> n;
		return s[0];
	endfunction

	// Pixel n of the byte, leftmost pixel first
	function automatic logic [4:0] pen_index(input logic [1:0] mode, input logic [7:0] dv,
		input logic [2:0] pix);
		logic [4:0] idx;
		int p;
		idx = '0;
		case (mode)
			MODE_2BPP:
			begin
				p = int'(pix[2:1]);
				idx[1] = shifted_bit(dv, 3 - p);
				idx[0] = shifted_bit(dv, 7 - p);
			end
			MODE_1BPP:
				idx[0] = shifted_bit(dv, 7 - int'(pix));
			default:
			begin
				// Pen bit i sits at 7 - 2i, one lower for the right pixel
				p = int'(pix[2]);
				for (int i = 0; i < 4; i++)
					idx[i] = shifted_bit(dv, 7 - 2 * i - p);
			end
		endcase
		return idx;
	endfunction

	// ROM visible on reads of the top or bottom 16K
	function automatic logic expected_nromen();
		logic mem_rd;
		mem_rd = !nmreq_i && !nrd_i;
		return !(mem_rd && (((a_i[15:14] == 2'b11) && !m_urom_dis) ||
			((a_i[15:14] == 2'b00) && !m_lrom_dis)));
	endfunction

	task automatic reset_model();
		m_pen = '0;
		m_mode = '0;
		m_urom_dis = 1'b0;
		m_lrom_dis = 1'b0;
		m_romsel = '0;
		m_ramsel = '0;
		for (int i = 0; i < 17; i++)
			m_ink[i] = '0;
		m_ink_wr_prev = 1'b0;
		m_rmr_wr_prev = 1'b0;
		m_color = HW_COLOUR_RGB[0];
		m_hs_prev = 1'b0;
		m_vs_prev = 1'b0;
		m_ack_prev = 1'b0;
		m_count = '0;
		m_vs_wait = 1'b0;
		m_vs_falls = '0;
		m_low = 1'b0;
		m_low_clks = '0;
	endtask

	// One rising edge, fed with the inputs seen before the edge
	task automatic step_model();
		ga_cmd_u cmd;
		logic io_wr;
		logic ga_wr;
		logic ink_wr;
		logic rmr_wr;
		logic clear;
		logic hs_fall;
		logic vs_rise;
		logic ack_rise;
		logic realign;
		logic raise;
		cmd = d_i;
		io_wr = !nioreq_i && !nwr_i;
		ga_wr = io_wr && (a_i[15:14] == 2'b01);
		ink_wr = ga_wr && (cmd.pen.fn == FN_INK);
		rmr_wr = ga_wr && (cmd.rmr.fn == FN_RMR);
		clear = rmr_wr && !m_rmr_wr_prev && cmd.rmr.int_clear;
		// Old palette and mode pick the colour
		m_color = HW_COLOUR_RGB[m_ink[border_i ? BORDER_PEN :
			pen_index(m_mode, dv_i, video_pixel_i)]];
		if (ink_wr && !m_ink_wr_prev && (m_pen <= BORDER_PEN))
			m_ink[m_pen] = cmd.pen.val;
		if (ga_wr && (cmd.pen.fn == FN_PEN))
			m_pen = cmd.pen.val;
		if (rmr_wr)
		begin
			m_mode = cmd.rmr.mode;
			m_urom_dis = cmd.rmr.urom_dis;
			m_lrom_dis = cmd.rmr.lrom_dis;
		end
		if (io_wr && !a_i[15] && (cmd.mmr.fn == FN_MMR))
			m_ramsel = {cmd.mmr.cfg[2], a_i[10:8], cmd.mmr.cfg[5:3], cmd.mmr.cfg[1:0]};
		if (io_wr && !a_i[13])
			m_romsel = d_i[5:0];
		m_ink_wr_prev = ink_wr;
		m_rmr_wr_prev = rmr_wr;

		// Line count and vsync re-alignment
		hs_fall = m_hs_prev && !hsync_i;
		vs_rise = vsync_i && !m_vs_prev;
		ack_rise = !nioreq_i && !nm1_i && !m_ack_prev;
		realign = m_vs_wait && hs_fall && (m_vs_falls == VSYNC_DELAY - 2'd1);
		raise = 1'b0;
		if (clear)
			m_count = '0;
		else if (realign)
		begin
			raise = (m_count >= 6'd32);
			m_count = '0;
		end
		else
		begin
			if (hs_fall)
			begin
				m_count = (m_count == HSYNC_PERIOD - 6'd1) ? 6'd0 : m_count + 6'd1;
				raise = (m_count == 6'd0);
			end
			if (ack_rise)
				m_count[5] = 1'b0;
		end
		if (vs_rise)
		begin
			m_vs_wait = 1'b1;
			m_vs_falls = '0;
		end
		else if (realign)
			m_vs_wait = 1'b0;
		else if (m_vs_wait && hs_fall)
			m_vs_falls = m_vs_falls + 2'd1;

		// INT low until ack, clear or the hold limit
		if (clear)
			m_low = 1'b0;
		else if (!m_low)
		begin
			if (raise)
			begin
				m_low = 1'b1;
				m_low_clks = 7'd1;
			end
		end
		else if (ack_rise || (m_low_clks == INT_HOLD_MAX))
			m_low = 1'b0;
		else
			m_low_clks = m_low_clks + 7'd1;
		m_hs_prev = hsync_i;
		m_vs_prev = vsync_i;
		m_ack_prev = !nioreq_i && !nm1_i;
	endtask

//--- testbench/tb_gate_array.sv
`timescale 1ns/1ps

module tb_gate_array;
	import gate_array_pkg::*;

	logic        clk_i;
	logic        nreset_i;
	logic [15:0] a_i;
	logic [7:0]  d_i;
	logic        nwr_i;
	logic        nrd_i;
	logic        nmreq_i;
	logic        nioreq_i;
	logic        nm1_i;
	logic        nint_o;
	logic        nromen_o;
	logic [5:0]  romsel_o;
	logic [8:0]  ramsel_o;
	logic [7:0]  dv_i;
	logic [2:0]  video_pixel_i;
	logic        border_i;
	logic        vsync_i;
	logic        hsync_i;
	logic [23:0] color_dat_o;
	// Run totals
	int          errors;
	int          checks;
	logic        timed_out;
	logic [31:0] seed;
	// Stimulus state
	int          op_left;
	int          line_pos;
	int          line_len;
	int          lines_to_vs;
	int          vs_left;
	logic        ack_on;
	logic        writes_on;
	logic        border_force;
	logic [15:0] wr_addr_q [$];
	logic [7:0]  wr_data_q [$];

	`include "tb_model.svh"

	gate_array UUT (
		.clk_i         (clk_i),
		.nreset_i      (nreset_i),
		.a_i           (a_i),
		.d_i           (d_i),
		.nwr_i         (nwr_i),
		.nrd_i         (nrd_i),
		.nmreq_i       (nmreq_i),
		.nioreq_i      (nioreq_i),
		.nm1_i         (nm1_i),
		.nint_o        (nint_o),
		.nromen_o      (nromen_o),
		.romsel_o      (romsel_o),
		.ramsel_o      (ramsel_o),
		.dv_i          (dv_i),
		.video_pixel_i (video_pixel_i),
		.border_i      (border_i),
		.vsync_i       (vsync_i),
		.hsync_i       (hsync_i),
		.color_dat_o   (color_dat_o)
	);

	// 100 ns clock
	always #50 clk_i = ~clk_i;

	// ==========================================================
	// Stimulus
	// ==========================================================

	// LCG, upper half only since the low bits repeat quickly
	function automatic logic [15:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	task automatic set_bus_idle(input logic [15:0] addr);
		a_i <= addr;
		nwr_i <= 1'b1;
		nrd_i <= 1'b1;
		nmreq_i <= 1'b1;
		nioreq_i <= 1'b1;
		nm1_i <= 1'b1;
	endtask

	// Z80 OUT, held three clocks
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a_i <= addr;
		d_i <= data;
		nioreq_i <= 1'b0;
		nwr_i <= 1'b0;
		op_left = 3;
	endtask

	task automatic acknowledge();
		nioreq_i <= 1'b0;
		nm1_i <= 1'b0;
		op_left = 2;
	endtask

	task automatic queue_io_write(input logic [15:0] addr, input logic [7:0] data);
		wr_addr_q.push_back(addr);
		wr_data_q.push_back(data);
	endtask

	task automatic start_bus_op();
		logic [15:0] r;
		logic [15:0] r2;
		logic [15:0] r3;
		logic [4:0]  pen5;
		r = next_random();
		r2 = next_random();
		r3 = next_random();
		pen5 = r3[12:8] % 5'd17;
		set_bus_idle(r2);
		op_left = 0;
		// Queued directed writes go first
		if (wr_addr_q.size() != 0)
			io_write(wr_addr_q.pop_front(), wr_data_q.pop_front());
		else if (r[15:11] < 5'd8)
		begin
			if (ack_on && m_low)
				acknowledge();
		end
		else if (r[15:11] == 5'd8)
		begin
			// Stray ack, only trims the count
			if (ack_on)
				acknowledge();
		end
		else if (r[15:11] < 5'd14)
		begin
			nmreq_i <= 1'b0;
			nrd_i <= 1'b0;
			op_left = 2;
		end
		else if ((r[15:11] < 5'd22) && writes_on)
		begin
			case (r2[15:13])
				3'd0: io_write(16'h7f00 | {8'h00, r3[7:0]}, {3'b000, pen5});
				3'd2: io_write(16'h7f00 | {8'h00, r3[7:0]},
					{2'b10, 1'b0, r3[15:11] == 5'd0, r[3:0]});
				3'd3: io_write({1'b0, r3[14:0]}, {2'b11, r[5:0]});
				3'd4: io_write(16'hdf00 | {8'h00, r3[7:0]}, r3[15:8]);
				default: io_write(16'h7f00 | {8'h00, r3[7:0]}, {2'b01, r3[13:8]});
			endcase
		end
	endtask

	task automatic drive_stimulus();
		logic [15:0] r;
		r = next_random();
		dv_i <= r[15:8];
		video_pixel_i <= r[7:5];
		border_i <= border_force || (r[4:2] == 3'd0);
		// New line, hsync high two clocks
		if (line_pos == 0)
		begin
			r = next_random();
			line_len = 8 + int'(r[15:13]);
			if (lines_to_vs == 0)
			begin
				vs_left = 4;
				lines_to_vs = 100 + int'(r[11:4]);
			end
			else
				lines_to_vs--;
			vsync_i <= (vs_left != 0);
			if (vs_left != 0)
				vs_left--;
		end
		hsync_i <= (line_pos < 2);
		line_pos = (line_pos + 1 == line_len) ? 0 : line_pos + 1;
		// Bus op, then one idle clock
		if (op_left > 1)
			op_left--;
		else if (op_left == 1)
		begin
			set_bus_idle(r);
			op_left = 0;
		end
		else
			start_bus_op();
	endtask

	// ==========================================================
	// Checks
	// ==========================================================

	task automatic report_mismatch(input string what, input logic [23:0] got,
		input logic [23:0] exp);
		errors++;
		$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
	endtask

	task automatic check_outputs();
		checks += 5;
		assert (nint_o === !m_low)
			else report_mismatch("nint_o", 24'(nint_o), 24'(!m_low));
		assert (nromen_o === expected_nromen())
			else report_mismatch("nromen_o", 24'(nromen_o), 24'(expected_nromen()));
		assert (romsel_o === m_romsel)
			else report_mismatch("romsel_o", 24'(romsel_o), 24'(m_romsel));
		assert (ramsel_o === m_ramsel)
			else report_mismatch("ramsel_o", 24'(ramsel_o), 24'(m_ramsel));
		assert (color_dat_o === m_color)
			else report_mismatch("color_dat_o", color_dat_o, m_color);
	endtask

	// Model and DUT step on the same edge, outputs compared mid-cycle
	task automatic run_cycle();
		@(posedge clk_i);
		step_model();
		drive_stimulus();
		@(negedge clk_i);
		check_outputs();
	endtask

	task automatic run_cycles(input int n);
		repeat (n) run_cycle();
	endtask

	task automatic wait_for_nint(input logic level, input int limit);
		int n;
		n = 0;
		while ((nint_o !== level) && (n < limit))
		begin
			run_cycle();
			n++;
		end
		if (nint_o !== level)
		begin
			$display("Timeout: nint_o did not go %s within %0d clocks",
				level ? "high" : "low", limit);
			timed_out = 1'b1;
		end
	endtask

	// ==========================================================
	// Sequence
	// ==========================================================

	initial
	begin
		clk_i = 1'b0;
		nreset_i = 1'b0;
		a_i = '0;
		d_i = '0;
		nwr_i = 1'b1;
		nrd_i = 1'b1;
		nmreq_i = 1'b1;
		nioreq_i = 1'b1;
		nm1_i = 1'b1;
		dv_i = '0;
		video_pixel_i = '0;
		border_i = 1'b0;
		vsync_i = 1'b0;
		hsync_i = 1'b0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		seed = 32'd4;
		op_left = 0;
		line_pos = 0;
		line_len = 8;
		lines_to_vs = 50;
		vs_left = 0;
		ack_on = 1'b0;
		writes_on = 1'b1;
		border_force = 1'b0;

		// Reset for 16 clocks
		repeat (16) @(posedge clk_i);
		reset_model();
		nreset_i <= 1'b1;
		@(negedge clk_i);
		checks += 4;
		assert (nint_o === 1'b1)
			else report_mismatch("nint_o after reset", 24'(nint_o), 24'd1);
		assert (romsel_o === 6'd0)
			else report_mismatch("romsel_o after reset", 24'(romsel_o), 24'd0);
		assert (ramsel_o === 9'd0)
			else report_mismatch("ramsel_o after reset", 24'(ramsel_o), 24'd0);
		assert (color_dat_o === HW_COLOUR_RGB[0])
			else report_mismatch("color_dat_o after reset", color_dat_o, HW_COLOUR_RGB[0]);
		check_outputs();

		// No acks, every interrupt runs out its hold time
		run_cycles(8000);

		// Border ink, then border forced on
		queue_io_write(16'h7f00, {3'b000, BORDER_PEN});
		queue_io_write(16'h7f00, 8'h4b);
		run_cycles(40);
		border_force = 1'b1;
		run_cycles(200);
		border_force = 1'b0;

		// Acks released by the CPU, strays clear bit 5
		ack_on = 1'b1;
		run_cycles(12000);

		// RMR interrupt clear while INT is low, quiet bus until the next interrupt
		ack_on = 1'b0;
		writes_on = 1'b0;
		wait_for_nint(1'b1, 200);
		if (!timed_out)
			wait_for_nint(1'b0, 2000);
		if (!timed_out)
		begin
			queue_io_write(16'h7f00, 8'b1001_0000);
			run_cycles(8);
			checks++;
			assert (nint_o === 1'b1)
				else report_mismatch("nint_o after RMR clear", 24'(nint_o), 24'd1);
			wait_for_nint(1'b0, 2000);
		end
		if (!timed_out)
			wait_for_nint(1'b1, 200);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
		if ((errors == 0) && !timed_out)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- video/pixel_decoder.sv
`timescale 1ns/1ps

module pixel_decoder (
	input  logic        clk_i,
	input  logic        nreset_i,
	input  logic [7:0]  dv_i,
	input  logic [2:0]  video_pixel_i,
	input  logic        border_i,
	input  logic [1:0]  mode_i,
	input  logic        ink_we_i,
	input  logic [4:0]  ink_pen_i,
	input  logic [4:0]  ink_val_i,
	output logic [23:0] color_dat_o
);
	import gate_array_pkg::*;

	// 16 pens plus border
	logic [4:0]  ink_q [17];
	logic [3:0]  m0_pen;
	logic [1:0]  m1_pen;
	logic        m2_pen;
	logic [4:0]  pen;
	logic [4:0]  hw_col;
	logic [23:0] color_q;

	// ==========================================================
	// Pixel extraction
	// ==========================================================

	// Mode 0, two pixels per byte, bits interleaved
	// Even pixel on the odd bit positions
	always_comb
	begin
		if (!video_pixel_i[2])
			m0_pen = {dv_i[1], dv_i[3], dv_i[5], dv_i[7]};
		else
			m0_pen = {dv_i[0], dv_i[2], dv_i[4], dv_i[6]};
	end

	// Mode 1, four pixels, low bit from the high nibble
	always_comb
	begin
		case (video_pixel_i[2:1])
			2'd0: m1_pen = {dv_i[3], dv_i[7]};
			2'd1: m1_pen = {dv_i[2], dv_i[6]};
			2'd2: m1_pen = {dv_i[1], dv_i[5]};
			default: m1_pen = {dv_i[0], dv_i[4]};
		endcase
	end

	// Mode 2, eight pixels MSB first
	// 7 - n is the bitwise inverse for 3 bits
	assign m2_pen = dv_i[~video_pixel_i];

	// Pen select, border overrides the video byte
	always_comb
	begin
		if (border_i)
			pen = BORDER_PEN;
		else
		begin
			case (mode_i)
				MODE_2BPP: pen = {3'b000, m1_pen};
				MODE_1BPP: pen = {4'b0000, m2_pen};
				// Mode 0 and the unused code 3
				default: pen = {1'b0, m0_pen};
			endcase
		end
	end

	assign hw_col = ink_q[pen];

	// ==========================================================
	// Palette and output
	// ==========================================================

	always_ff @(posedge clk_i)
	begin
		if (!nreset_i)
		begin
			for (int i = 0; i < 17; i++)
				ink_q[i] <= '0;
		end
		else if (ink_we_i && (ink_pen_i <= BORDER_PEN))
			ink_q[ink_pen_i] <= ink_val_i;
	end

	// One clock from video inputs to RGB
	// Cleared palette shows hardware colour 0
	always_ff @(posedge clk_i)
	begin
		if (!nreset_i)
			color_q <= HW_COLOUR_RGB[0];
		else
			color_q <= HW_COLOUR_RGB[hw_col];
	end

	assign color_dat_o = color_q;

	// Pens 17 to 31 have no palette slot
	a_pen_range: assert property (@(posedge clk_i) disable iff (!nreset_i)
		ink_we_i |-> (ink_pen_i <= BORDER_PEN))
		else $warning("pixel_decoder: ink write to pen %0d ignored", ink_pen_i);

endmodule
